//--- rv_pkg.sv
// ------------------------------------------------
// RV32I back-end package
// Widths, vector types, major opcodes, access
// sizes and data memory depth
// ------------------------------------------------
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;      // Operands, results, PCs, memory data
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [1:0]      size_t;      // Load/store access size

    // Major opcodes, standard RV32I encodings
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // Access sizes, same as func3[1:0] of loads and stores
    localparam size_t SIZE_BYTE = 2'b00;
    localparam size_t SIZE_HALF = 2'b01;
    localparam size_t SIZE_WORD = 2'b10;

    // Data memory, 64 words so byte addresses use bits 7:0
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

endpackage

`default_nettype wire

//--- execute_stage.sv
// ------------------------------------------------
// Execute stage
// Control decode, ALU, branch condition and
// target, PC+4
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  rv_pkg::opcode_t i_opcode,
    input  rv_pkg::funct3_t i_func3,
    input  logic            i_func7b5,
    input  rv_pkg::word_t   i_rs1_data,
    input  rv_pkg::word_t   i_rs2_data,
    input  rv_pkg::word_t   i_imm,
    input  rv_pkg::word_t   i_pc,
    output logic            o_reg_write,
    output logic            o_mem_read,
    output logic            o_mem_write,
    output logic            o_mem_to_reg,
    output logic            o_branch_taken,
    output logic            o_link_reg,
    output logic            o_load_unsigned,
    output rv_pkg::size_t   o_data_size,
    output rv_pkg::word_t   o_pc_next,
    output rv_pkg::word_t   o_branch_addr,
    output rv_pkg::word_t   o_alu
);
    import rv_pkg::*;

    logic  is_op, is_op_imm, is_load, is_store;
    logic  is_branch, is_jal, is_jalr, is_lui;
    logic  cond;
    word_t op2;
    word_t jalr_sum;
    logic [4:0] shamt;

    assign is_op     = (i_opcode == OPC_OP);
    assign is_op_imm = (i_opcode == OPC_OP_IMM);
    assign is_load   = (i_opcode == OPC_LOAD);
    assign is_store  = (i_opcode == OPC_STORE);
    assign is_branch = (i_opcode == OPC_BRANCH);
    assign is_jal    = (i_opcode == OPC_JAL);
    assign is_jalr   = (i_opcode == OPC_JALR);
    assign is_lui    = (i_opcode == OPC_LUI);

    assign o_reg_write     = is_op | is_op_imm | is_load | is_jal | is_jalr | is_lui;
    assign o_mem_read      = is_load;
    assign o_mem_write     = is_store;
    assign o_mem_to_reg    = is_load;
    assign o_link_reg      = is_jal | is_jalr;   // Writes PC+4
    assign o_data_size     = i_func3[1:0];
    assign o_load_unsigned = i_func3[2];         // LBU, LHU

    assign op2   = (is_op || is_branch) ? i_rs2_data : i_imm;
    assign shamt = op2[4:0];

    always_comb begin
        o_alu = i_rs1_data + op2;                // Loads, stores, JALR use the sum
        if (is_lui) begin
            o_alu = i_imm;
        end else if (is_op || is_op_imm) begin
            case (i_func3)
                3'b000:  o_alu = (is_op && i_func7b5) ? i_rs1_data - op2 : i_rs1_data + op2;
                3'b001:  o_alu = i_rs1_data << shamt;
                3'b010:  o_alu = {31'b0, $signed(i_rs1_data) < $signed(op2)};
                3'b011:  o_alu = {31'b0, i_rs1_data < op2};
                3'b100:  o_alu = i_rs1_data ^ op2;
                3'b101:  o_alu = i_func7b5 ? word_t'($signed(i_rs1_data) >>> shamt)
                                           : i_rs1_data >> shamt;
                3'b110:  o_alu = i_rs1_data | op2;
                default: o_alu = i_rs1_data & op2;
            endcase
        end
    end

    // Branch condition on rs1 against rs2
    always_comb begin
        case (i_func3)
            3'b000:  cond = (i_rs1_data == op2);                  // BEQ
            3'b001:  cond = (i_rs1_data != op2);                  // BNE
            3'b100:  cond = ($signed(i_rs1_data) < $signed(op2));  // BLT
            3'b101:  cond = ($signed(i_rs1_data) >= $signed(op2)); // BGE
            3'b110:  cond = (i_rs1_data < op2);                   // BLTU
            3'b111:  cond = (i_rs1_data >= op2);                  // BGEU
            default: cond = 1'b0;
        endcase
    end

    assign o_branch_taken = (is_branch & cond) | is_jal | is_jalr;

    assign jalr_sum      = i_rs1_data + i_imm;
    assign o_branch_addr = is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : i_pc + i_imm;
    assign o_pc_next     = i_pc + 32'd4;

endmodule

`default_nettype wire

//--- ex_mem_reg.sv
// ------------------------------------------------
// EX/MEM pipeline register
// All fields load on enable, reset clears valid
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ex_mem_reg (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_en,             // Low while stalled
    input  logic              i_valid,
    input  logic              i_reg_write,
    input  logic              i_mem_read,
    input  logic              i_mem_write,
    input  logic              i_mem_to_reg,
    input  logic              i_branch_taken,
    input  logic              i_link_reg,
    input  logic              i_load_unsigned,
    input  rv_pkg::size_t     i_data_size,
    input  rv_pkg::word_t     i_pc_next,
    input  rv_pkg::word_t     i_branch_addr,
    input  rv_pkg::word_t     i_alu,
    input  rv_pkg::word_t     i_data2,          // Store data
    input  rv_pkg::reg_addr_t i_rd_addr,
    output logic              o_valid,
    output logic              o_reg_write,
    output logic              o_mem_read,
    output logic              o_mem_write,
    output logic              o_mem_to_reg,
    output logic              o_branch_taken,
    output logic              o_link_reg,
    output logic              o_load_unsigned,
    output rv_pkg::size_t     o_data_size,
    output rv_pkg::word_t     o_pc_next,
    output rv_pkg::word_t     o_branch_addr,
    output rv_pkg::word_t     o_alu,
    output rv_pkg::word_t     o_data2,
    output rv_pkg::reg_addr_t o_rd_addr
);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else if (i_en) begin
            o_valid <= i_valid;
        end
    end

    // Payload fields, no reset
    always_ff @(posedge clk) begin
        if (i_en) begin
            o_reg_write     <= i_reg_write;
            o_mem_read      <= i_mem_read;
            o_mem_write     <= i_mem_write;
            o_mem_to_reg    <= i_mem_to_reg;
            o_branch_taken  <= i_branch_taken;
            o_link_reg      <= i_link_reg;
            o_load_unsigned <= i_load_unsigned;
            o_data_size     <= i_data_size;
            o_pc_next       <= i_pc_next;
            o_branch_addr   <= i_branch_addr;
            o_alu           <= i_alu;
            o_data2         <= i_data2;
            o_rd_addr       <= i_rd_addr;
        end
    end

    // Upstream must hold its instruction while stalled
    a_no_strobe_in_stall: assert property (@(posedge clk) disable iff (i_reset)
        !i_en |-> !i_valid)
        else $error("ex_mem_reg: instruction strobe while stalled");

    a_valid_after_reset: assert property (@(posedge clk) i_reset |=> !o_valid)
        else $error("ex_mem_reg: valid set in the cycle after reset");

endmodule

`default_nettype wire

//--- data_mem.sv
// ------------------------------------------------
// Data memory
// Word array with byte-lane stores and
// combinational loads with sign/zero extension
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module data_mem (
    input  logic          clk,
    input  logic          i_we,
    input  logic          i_re,
    input  rv_pkg::word_t i_addr,
    input  rv_pkg::word_t i_wdata,
    input  rv_pkg::size_t i_size,
    input  logic          i_unsigned,
    output rv_pkg::word_t o_rdata
);
    import rv_pkg::*;

    word_t mem [DMEM_WORDS];

    logic [DMEM_IDX_W-1:0] idx;
    logic [1:0]            lane;
    word_t                 rd_word;
    logic [7:0]            rd_byte;
    logic [15:0]           rd_half;

    // Upper address bits ignored, memory wraps
    assign idx  = i_addr[DMEM_IDX_W+1:2];
    assign lane = i_addr[1:0];

    always_ff @(posedge clk) begin
        if (i_we) begin
            case (i_size)
                SIZE_BYTE: mem[idx][8*lane +: 8]      <= i_wdata[7:0];
                SIZE_HALF: mem[idx][16*lane[1] +: 16] <= i_wdata[15:0];
                default:   mem[idx]                   <= i_wdata;
            endcase
        end
    end

    assign rd_word = mem[idx];
    assign rd_byte = rd_word[8*lane +: 8];
    assign rd_half = rd_word[16*lane[1] +: 16];

    // Lane select and extension
    always_comb begin
        o_rdata = '0;
        if (i_re) begin
            case (i_size)
                SIZE_BYTE: begin
                    o_rdata = i_unsigned ? {24'b0, rd_byte} : {{24{rd_byte[7]}}, rd_byte};
                end
                SIZE_HALF: begin
                    o_rdata = i_unsigned ? {16'b0, rd_half} : {{16{rd_half[15]}}, rd_half};
                end
                default: o_rdata = rd_word;
            endcase
        end
    end

    // Halfwords on even addresses, words on multiples of 4
    a_aligned: assert property (@(posedge clk)
        (i_we || i_re) |->
            !((i_size == SIZE_HALF && i_addr[0]) ||
              (i_size == SIZE_WORD && i_addr[1:0] != 2'b00)))
        else $error("data_mem: misaligned access at %h", i_addr);

endmodule

`default_nettype wire

//--- mem_wb_reg.sv
// ------------------------------------------------
// MEM/WB pipeline register
// Picks load data, PC+4 or ALU result and
// registers it with rd
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mem_wb_reg (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_en,
    input  logic              i_valid,
    input  logic              i_reg_write,
    input  logic              i_mem_to_reg,
    input  logic              i_link_reg,       // JAL, JALR
    input  rv_pkg::word_t     i_alu,
    input  rv_pkg::word_t     i_pc_next,
    input  rv_pkg::word_t     i_load_data,
    input  rv_pkg::reg_addr_t i_rd_addr,
    output logic              o_wb_valid,
    output rv_pkg::reg_addr_t o_wb_rd,
    output rv_pkg::word_t     o_wb_data
);
    import rv_pkg::*;

    word_t wb_value;
    logic  wb_write;

    always_comb begin
        if (i_mem_to_reg) begin
            wb_value = i_load_data;
        end else if (i_link_reg) begin
            wb_value = i_pc_next;     // Return address
        end else begin
            wb_value = i_alu;
        end
    end

    // x0 writes are dropped here
    assign wb_write = i_valid & i_reg_write & (i_rd_addr != 5'd0);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_wb_valid <= 1'b0;
        end else if (i_en) begin
            o_wb_valid <= wb_write;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_wb_rd   <= i_rd_addr;
            o_wb_data <= wb_value;
        end
    end

endmodule

`default_nettype wire

//--- exec_backend.sv
// ------------------------------------------------
// RV32I pipeline back end
// Execute, EX/MEM, memory access and MEM/WB
// with redirect and writeback outputs
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module exec_backend (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_stall,
    input  logic              i_valid,
    input  rv_pkg::opcode_t   i_opcode,
    input  rv_pkg::funct3_t   i_func3,
    input  logic              i_func7b5,
    input  rv_pkg::word_t     i_rs1_data,
    input  rv_pkg::word_t     i_rs2_data,
    input  rv_pkg::word_t     i_imm,
    input  rv_pkg::word_t     i_pc,
    input  rv_pkg::reg_addr_t i_rd_addr,
    output logic              o_redirect,
    output rv_pkg::word_t     o_redirect_pc,
    output logic              o_wb_valid,
    output rv_pkg::reg_addr_t o_wb_rd,
    output rv_pkg::word_t     o_wb_data
);
    import rv_pkg::*;

    logic  en;
    logic  ex_reg_write, ex_mem_read, ex_mem_write, ex_mem_to_reg;
    logic  ex_branch_taken, ex_link_reg, ex_load_unsigned;
    size_t ex_data_size;
    word_t ex_pc_next, ex_branch_addr, ex_alu;

    logic      m_valid, m_reg_write, m_mem_read, m_mem_write, m_mem_to_reg;
    logic      m_branch_taken, m_link_reg, m_load_unsigned;
    size_t     m_data_size;
    word_t     m_pc_next, m_branch_addr, m_alu, m_data2;
    reg_addr_t m_rd_addr;
    word_t     load_data;

    assign en = ~i_stall;

    execute_stage execute_stage_inst (
        .i_opcode(i_opcode), .i_func3(i_func3), .i_func7b5(i_func7b5),
        .i_rs1_data(i_rs1_data), .i_rs2_data(i_rs2_data), .i_imm(i_imm), .i_pc(i_pc),
        .o_reg_write(ex_reg_write), .o_mem_read(ex_mem_read), .o_mem_write(ex_mem_write),
        .o_mem_to_reg(ex_mem_to_reg), .o_branch_taken(ex_branch_taken),
        .o_link_reg(ex_link_reg), .o_load_unsigned(ex_load_unsigned),
        .o_data_size(ex_data_size), .o_pc_next(ex_pc_next),
        .o_branch_addr(ex_branch_addr), .o_alu(ex_alu)
    );

    ex_mem_reg ex_mem_reg_inst (
        .clk(clk), .i_reset(i_reset), .i_en(en), .i_valid(i_valid),
        .i_reg_write(ex_reg_write), .i_mem_read(ex_mem_read), .i_mem_write(ex_mem_write),
        .i_mem_to_reg(ex_mem_to_reg), .i_branch_taken(ex_branch_taken),
        .i_link_reg(ex_link_reg), .i_load_unsigned(ex_load_unsigned),
        .i_data_size(ex_data_size), .i_pc_next(ex_pc_next), .i_branch_addr(ex_branch_addr),
        .i_alu(ex_alu), .i_data2(i_rs2_data), .i_rd_addr(i_rd_addr),
        .o_valid(m_valid), .o_reg_write(m_reg_write), .o_mem_read(m_mem_read),
        .o_mem_write(m_mem_write), .o_mem_to_reg(m_mem_to_reg),
        .o_branch_taken(m_branch_taken), .o_link_reg(m_link_reg),
        .o_load_unsigned(m_load_unsigned), .o_data_size(m_data_size),
        .o_pc_next(m_pc_next), .o_branch_addr(m_branch_addr), .o_alu(m_alu),
        .o_data2(m_data2), .o_rd_addr(m_rd_addr)
    );

    // Memory strobes only for a live instruction
    data_mem data_mem_inst (
        .clk(clk), .i_we(m_valid & m_mem_write), .i_re(m_valid & m_mem_read),
        .i_addr(m_alu), .i_wdata(m_data2), .i_size(m_data_size),
        .i_unsigned(m_load_unsigned), .o_rdata(load_data)
    );

    mem_wb_reg mem_wb_reg_inst (
        .clk(clk), .i_reset(i_reset), .i_en(en), .i_valid(m_valid),
        .i_reg_write(m_reg_write), .i_mem_to_reg(m_mem_to_reg), .i_link_reg(m_link_reg),
        .i_alu(m_alu), .i_pc_next(m_pc_next), .i_load_data(load_data),
        .i_rd_addr(m_rd_addr),
        .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data)
    );

    assign o_redirect    = m_valid & m_branch_taken;
    assign o_redirect_pc = m_branch_addr;

endmodule

`default_nettype wire

//--- tb_exec_backend.sv
// ------------------------------------------------
// Testbench for the RV32I pipeline back end
// Reference model of the instruction semantics and
// the data memory, results checked in order
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_exec_backend;
    import rv_pkg::*;

    logic      clk = 1'b0;
    logic      i_reset, i_stall, i_valid, i_func7b5;
    opcode_t   i_opcode;
    funct3_t   i_func3;
    word_t     i_rs1_data, i_rs2_data, i_imm, i_pc;
    reg_addr_t i_rd_addr;
    logic      o_redirect, o_wb_valid;
    word_t     o_redirect_pc, o_wb_data;
    reg_addr_t o_wb_rd;

    integer      seed = 32'hcbc4;
    word_t       shadow [DMEM_WORDS];
    logic [68:0] wb_q [$];      // {cycle, rd, data}
    logic [63:0] redir_q [$];   // {cycle, target}
    int          adv;           // Edges where the pipeline moved
    logic        advanced;
    logic        stalled;       // Last edge was a stall
    int          stall_max;

    // Outputs seen at the previous falling edge
    logic        prev_wb_valid, prev_redirect;
    reg_addr_t   prev_wb_rd;
    word_t       prev_wb_data, prev_redirect_pc;

    exec_backend exec_backend_inst (
        .clk(clk), .i_reset(i_reset), .i_stall(i_stall), .i_valid(i_valid),
        .i_opcode(i_opcode), .i_func3(i_func3), .i_func7b5(i_func7b5),
        .i_rs1_data(i_rs1_data), .i_rs2_data(i_rs2_data), .i_imm(i_imm), .i_pc(i_pc),
        .i_rd_addr(i_rd_addr), .o_redirect(o_redirect), .o_redirect_pc(o_redirect_pc),
        .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic word_t rand32();
        return $random(seed);
    endfunction

    // Clear the low address bits for the access size
    function automatic word_t align(input word_t addr, input funct3_t f3);
        return addr & ~((32'd1 << f3[1:0]) - 32'd1);
    endfunction

    // Expected result of one instruction
    function automatic void predict(
        input opcode_t opc, input funct3_t f3, input logic f7,
        input word_t a, input word_t b, input word_t imm, input word_t pc,
        input reg_addr_t rd, input word_t mem [DMEM_WORDS],
        output logic wr, output word_t data, output logic redir, output word_t target);
        word_t       op2;
        word_t       addr;
        word_t       w;
        logic [7:0]  by;
        logic [15:0] hw;
        op2    = (opc == OPC_OP) ? b : imm;
        addr   = a + imm;
        w      = mem[addr[7:2]];
        by     = w[8*addr[1:0] +: 8];
        hw     = w[16*addr[1] +: 16];
        wr     = 1'b0;
        data   = '0;
        redir  = 1'b0;
        target = pc + imm;
        case (opc)
            OPC_OP, OPC_OP_IMM: begin
                wr = 1'b1;
                case (f3)
                    3'd0:    data = (opc == OPC_OP && f7) ? a - op2 : a + op2;
                    3'd1:    data = a << op2[4:0];
                    3'd2:    data = ($signed(a) < $signed(op2)) ? 32'd1 : 32'd0;
                    3'd3:    data = (a < op2) ? 32'd1 : 32'd0;
                    3'd4:    data = a ^ op2;
                    3'd5:    data = f7 ? word_t'($signed(a) >>> op2[4:0]) : a >> op2[4:0];
                    3'd6:    data = a | op2;
                    default: data = a & op2;
                endcase
            end
            OPC_LUI: begin
                wr   = 1'b1;
                data = imm;
            end
            OPC_LOAD: begin
                wr = 1'b1;
                case (f3)
                    3'd0:    data = {{24{by[7]}}, by};
                    3'd1:    data = {{16{hw[15]}}, hw};
                    3'd4:    data = {24'b0, by};     // LBU
                    3'd5:    data = {16'b0, hw};
                    default: data = w;
                endcase
            end
            OPC_BRANCH: begin
                case (f3)
                    3'd0:    redir = (a == b);
                    3'd1:    redir = (a != b);
                    3'd4:    redir = ($signed(a) < $signed(b));
                    3'd5:    redir = ($signed(a) >= $signed(b));
                    3'd6:    redir = (a < b);
                    3'd7:    redir = (a >= b);
                    default: redir = 1'b0;
                endcase
            end
            OPC_JAL, OPC_JALR: begin
                wr    = 1'b1;
                data  = pc + 32'd4;
                redir = 1'b1;
                if (opc == OPC_JALR) begin
                    target = (a + imm) & ~32'd1;
                end
            end
            default: ;
        endcase
        wr = wr & (rd != 5'd0);   // x0 never written
    endfunction

    task automatic check(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    // Drive one instruction, record what it should produce, then stall a while
    task automatic issue(input opcode_t opc, input funct3_t f3, input logic f7,
                         input word_t a, input word_t b, input word_t imm,
                         input word_t pc, input reg_addr_t rd);
        logic  wr, redir;
        word_t data, target, addr;
        int    gap;
        i_valid    = 1'b1;
        i_stall    = 1'b0;
        i_opcode   = opc;
        i_func3    = f3;
        i_func7b5  = f7;
        i_rs1_data = a;
        i_rs2_data = b;
        i_imm      = imm;
        i_pc       = pc;
        i_rd_addr  = rd;
        predict(opc, f3, f7, a, b, imm, pc, rd, shadow, wr, data, redir, target);
        if (redir) redir_q.push_back({adv + 1, target});
        if (wr) wb_q.push_back({adv + 2, rd, data});
        if (opc == OPC_STORE) begin
            addr = a + imm;
            case (f3)
                3'd0:    shadow[addr[7:2]][8*addr[1:0] +: 8]  = b[7:0];
                3'd1:    shadow[addr[7:2]][16*addr[1] +: 16] = b[15:0];
                default: shadow[addr[7:2]] = b;
            endcase
        end
        @(posedge clk);
        #10;
        i_valid = 1'b0;
        gap = rand32() % (stall_max + 1);
        repeat (gap) begin
            i_stall = 1'b1;
            @(posedge clk);
            #10;
        end
        i_stall = 1'b0;
    endtask

    always @(posedge clk) begin
        advanced <= !i_stall && !i_reset;
        stalled  <= i_stall && !i_reset;
        if (i_reset) begin
            adv <= 0;
        end else if (!i_stall) begin
            adv <= adv + 1;
        end
    end

    // Outputs held by a stall are matched only once and must not move while held
    always @(negedge clk) begin
        logic [68:0] we;
        logic [63:0] re;
        if (i_reset) begin
            check("o_wb_valid in reset", {31'b0, o_wb_valid}, 32'd0);
            check("o_redirect in reset", {31'b0, o_redirect}, 32'd0);
        end else if (advanced) begin
            if (o_redirect) begin
                if (redir_q.size() == 0) begin
                    abort_run("Redirect raised with no branch or jump pending");
                end else begin
                    re = redir_q.pop_front();
                    check("redirect cycle", adv, re[63:32]);
                    check("o_redirect_pc", o_redirect_pc, re[31:0]);
                end
            end
            if (o_wb_valid) begin
                if (wb_q.size() == 0) begin
                    abort_run("Writeback raised with no register write pending");
                end else begin
                    we = wb_q.pop_front();
                    check("writeback cycle", adv, we[68:37]);
                    check("o_wb_rd", {27'b0, o_wb_rd}, {27'b0, we[36:32]});
                    check("o_wb_data", o_wb_data, we[31:0]);
                end
            end
        end else if (stalled) begin
            check("o_wb_valid in stall", {31'b0, o_wb_valid}, {31'b0, prev_wb_valid});
            check("o_wb_rd in stall", {27'b0, o_wb_rd}, {27'b0, prev_wb_rd});
            check("o_wb_data in stall", o_wb_data, prev_wb_data);
            check("o_redirect in stall", {31'b0, o_redirect}, {31'b0, prev_redirect});
            check("o_redirect_pc in stall", o_redirect_pc, prev_redirect_pc);
        end
        prev_wb_valid    = o_wb_valid;
        prev_wb_rd       = o_wb_rd;
        prev_wb_data     = o_wb_data;
        prev_redirect    = o_redirect;
        prev_redirect_pc = o_redirect_pc;
    end

    initial begin
        int      k, j, waited;
        word_t   r, a, b, imm, pc, addr;
        opcode_t opc;
        funct3_t f3;
        i_reset    = 1'b1;
        i_stall    = 1'b0;
        i_valid    = 1'b0;
        i_opcode   = '0;
        i_func3    = '0;
        i_func7b5  = 1'b0;
        i_rs1_data = '0;
        i_rs2_data = '0;
        i_imm      = '0;
        i_pc       = '0;
        i_rd_addr  = '0;
        stall_max  = 0;
        repeat (5) @(posedge clk);
        #10;
        i_reset = 1'b0;
        repeat (2) @(posedge clk);
        #10;

        // Known contents in every word before any load
        for (k = 0; k < DMEM_WORDS; k++) begin
            addr = word_t'(k * 4);
            b    = {addr[7:0] ^ 8'h5a, ~addr[7:0], addr[7:0], addr[7:0] ^ 8'hc3};
            issue(OPC_STORE, 3'd2, 1'b0, addr, b, 32'd0, 32'd0, 5'd0);
        end

        for (k = 0; k < 64; k++) begin
            r   = rand32();
            opc = (r[2:0] == 3'd7) ? OPC_LUI : (r[0] ? OPC_OP : OPC_OP_IMM);
            imm = (opc == OPC_LUI) ? {r[31:12], 12'b0} : {{20{r[31]}}, r[31:20]};
            issue(opc, k[2:0], r[3], rand32(), rand32(), imm, 32'd0, r[8:4]);
        end

        // Store, then loads of every size and sign in the same word
        for (k = 0; k < 24; k++) begin
            r    = rand32();
            f3   = (r[1:0] == 2'd3) ? 3'd2 : {1'b0, r[1:0]};
            addr = align(rand32(), f3);
            imm  = {{20{r[31]}}, r[31:22], 2'b00};
            issue(OPC_STORE, f3, 1'b0, addr - imm, rand32(), imm, 32'd0, 5'd0);
            for (j = 0; j < 5; j++) begin
                r    = rand32();
                f3   = (j < 3) ? funct3_t'(j) : funct3_t'(j + 1);
                addr = align({addr[31:2], r[1:0]}, f3);
                issue(OPC_LOAD, f3, 1'b0, addr - imm, 32'd0, imm, 32'd0, r[12:8]);
            end
        end

        for (k = 0; k < 48; k++) begin
            r  = rand32();
            a  = rand32();
            b  = r[3] ? a : (r[4] ? ~a : rand32());
            pc = rand32() & ~32'd3;
            f3 = (r[2:1] == 2'b01) ? {2'b00, r[0]} : r[2:0];
            issue(OPC_BRANCH, f3, 1'b0, a, b, {{19{r[31]}}, r[31:20], 1'b0}, pc, r[9:5]);
            if (k % 3 == 0) begin
                issue(r[5] ? OPC_JAL : OPC_JALR, 3'd0, 1'b0, a, 32'd0,
                      {{20{r[30]}}, r[30:19]}, pc, r[10:6]);
            end
        end

        // Back-to-back traffic with random stalls, every fourth rd is x0
        stall_max = 3;
        for (k = 0; k < 48; k++) begin
            r   = rand32();
            opc = (r[1:0] == 2'd0) ? OPC_JAL : (r[2] ? OPC_OP : OPC_OP_IMM);
            issue(opc, k[2:0], r[3], rand32(), rand32(), {{20{r[31]}}, r[31:20]},
                  rand32() & ~32'd3, (k % 4 == 0) ? 5'd0 : r[12:8]);
        end
        stall_max = 0;

        waited = 0;
        while ((wb_q.size() != 0 || redir_q.size() != 0) && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);   // Room for any stray output
        if (wb_q.size() != 0 || redir_q.size() != 0) begin
            $display("Timeout: %0d writebacks and %0d redirects never arrived",
                     wb_q.size(), redir_q.size());
            $display("TEST RESULT: FAIL");
            $fatal(1, "results missing at the end of the run");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
rv_pkg.sv
execute_stage.sv
ex_mem_reg.sv
data_mem.sv
mem_wb_reg.sv
exec_backend.sv
tb_exec_backend.sv

//--- run.sh
#!/bin/sh
# Build the back-end testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_exec_backend \
    -f verilog.f -o tb_sim \
    && ./obj_dir/tb_sim \
    || { echo "simulation did not complete cleanly"; exit 1; }
